/* include/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Address and PC width
`define ADDR_W 32

// Instruction word width
`define INSN_W 32

// log2 of bytes per instruction, also the PC byte-offset width
`define INSN_BYTES_LOG 2

// BTB index width (16 entries)
`define BTB_IDX_W 4

// log2 of fetch queue depth (4 entries)
`define FQ_DEPTH_LOG 2

// First fetch address after reset
`define RESET_PC 32'h0000_0100

`endif

/* verilog/fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

   // Fetch FSM states
   // FS_DISCARD waits out a bus cycle whose data a flush made stale
   typedef enum logic [1:0]
   {
      FS_IDLE    = 2'd0,
      FS_BUS     = 2'd1,
      FS_DISCARD = 2'd2
   } fetch_state_t;

   // One fetched instruction on its way to decode
   typedef struct packed
   {
      logic [`ADDR_W-1:0] pc;
      logic [`INSN_W-1:0] ins;
      logic               pred_taken;
   } fetch_entry_t;

endpackage

/* verilog/fetch_push_if.sv */
`timescale 1ns/1ps

// Push channel from the fetch controller into the fetch queue
interface fetch_push_if
   import fetch_pkg::*;
();

   logic         valid;
   fetch_entry_t entry;
   // Queue not full
   logic         ready;

   modport producer
   (
      output valid,
      output entry,
      input  ready
   );

   modport consumer
   (
      input  valid,
      input  entry,
      output ready
   );

endinterface

/* verilog/btb.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module btb
   import fetch_pkg::*;
#(
   parameter int IDX_W = `BTB_IDX_W
)
(
   input  logic               clk,
   input  logic               rst_n,
   // Lookup from fetch
   input  logic [`ADDR_W-1:0] lookup_pc,
   output logic               pred_hit,
   output logic [`ADDR_W-1:0] pred_tgt,
   // Training from execute
   input  logic               bpu_wb,
   input  logic               bpu_wb_taken,
   input  logic [`ADDR_W-1:0] bpu_wb_pc,
   input  logic [`ADDR_W-1:0] bpu_wb_tgt
);
   localparam int ENTRIES = 1 << IDX_W;
   localparam int TAG_W   = `ADDR_W - IDX_W - `INSN_BYTES_LOG;

   logic [ENTRIES-1:0] vld;
   logic [TAG_W-1:0]   tag_mem [ENTRIES];
   logic [`ADDR_W-1:0] tgt_mem [ENTRIES];
   logic [1:0]         cnt_mem [ENTRIES];

   logic [IDX_W-1:0]   lk_idx;
   logic [TAG_W-1:0]   lk_tag;
   logic [IDX_W-1:0]   up_idx;
   logic [TAG_W-1:0]   up_tag;
   logic               up_match;

   // Index sits just above the byte offset, tag takes the rest
   assign lk_idx = lookup_pc[`INSN_BYTES_LOG +: IDX_W];
   assign lk_tag = lookup_pc[`ADDR_W-1 -: TAG_W];
   assign up_idx = bpu_wb_pc[`INSN_BYTES_LOG +: IDX_W];
   assign up_tag = bpu_wb_pc[`ADDR_W-1 -: TAG_W];

   // Predict taken only on weakly or strongly taken counters
   assign pred_hit = vld[lk_idx] & (tag_mem[lk_idx] == lk_tag) & cnt_mem[lk_idx][1];
   assign pred_tgt = tgt_mem[lk_idx];

   assign up_match = vld[up_idx] & (tag_mem[up_idx] == up_tag);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         vld <= '0;
      else if (bpu_wb && bpu_wb_taken)
         vld[up_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (bpu_wb && bpu_wb_taken)
      begin
         tgt_mem[up_idx] <= bpu_wb_tgt;
         if (!up_match)
         begin
            // Allocate as weakly taken
            tag_mem[up_idx] <= up_tag;
            cnt_mem[up_idx] <= 2'd2;
         end
         else if (cnt_mem[up_idx] != 2'd3)
            cnt_mem[up_idx] <= cnt_mem[up_idx] + 2'd1;
      end
      else if (bpu_wb && up_match && cnt_mem[up_idx] != 2'd0)
         cnt_mem[up_idx] <= cnt_mem[up_idx] - 2'd1;
   end

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_ctrl
   import fetch_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   // Redirect from execute
   input  logic               flush,
   input  logic [`ADDR_W-1:0] flush_tgt,
   // BTB lookup
   output logic [`ADDR_W-1:0] lookup_pc,
   input  logic               pred_hit,
   input  logic [`ADDR_W-1:0] pred_tgt,
   // Wishbone classic read master
   output logic               wb_cyc,
   output logic               wb_stb,
   output logic [`ADDR_W-1:0] wb_adr,
   input  logic               wb_ack,
   input  logic [`INSN_W-1:0] wb_rdata,
   // Entries to the fetch queue
   fetch_push_if.producer     push
);
   localparam logic [`ADDR_W-1:0] PC_STEP = `ADDR_W'(1) << `INSN_BYTES_LOG;

   fetch_state_t       state;
   fetch_state_t       state_nxt;
   logic [`ADDR_W-1:0] pc;
   logic [`ADDR_W-1:0] pc_nxt;
   logic               start;
   logic               done;

   // New bus cycle only with queue space and no redirect pending
   assign start = (state == FS_IDLE) & push.ready & ~flush;
   assign done  = (state == FS_BUS) & wb_ack;

   // Next state
   always_comb
   begin
      state_nxt = state;
      case (state)
         FS_IDLE:
         begin
            if (start)
               state_nxt = FS_BUS;
         end
         FS_BUS:
         begin
            if (wb_ack)
               state_nxt = FS_IDLE;
            else if (flush)
               state_nxt = FS_DISCARD;
         end
         FS_DISCARD:
         begin
            // Stale data, drop it once the slave answers
            if (wb_ack)
               state_nxt = FS_IDLE;
         end
         default:
            state_nxt = FS_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= FS_IDLE;
      else
         state <= state_nxt;
   end

   // Next PC: flush wins, then prediction, then sequential step
   always_comb
   begin
      pc_nxt = pc;
      if (flush)
         pc_nxt = flush_tgt;
      else if (done)
         pc_nxt = pred_hit ? pred_tgt : pc + PC_STEP;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pc <= `RESET_PC;
      else
         pc <= pc_nxt;
   end

   // Bus address held for the whole cycle, even across a flush
   always_ff @(posedge clk)
   begin
      if (start)
         wb_adr <= pc;
   end

   assign wb_cyc = (state != FS_IDLE);
   assign wb_stb = wb_cyc;

   assign lookup_pc = pc;

   // A flush on the ack edge also kills the push
   assign push.valid = done & ~flush;
   assign push.entry = '{pc: wb_adr, ins: wb_rdata, pred_taken: pred_hit};

endmodule

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue
   import fetch_pkg::*;
#(
   parameter int DEPTH_LOG = `FQ_DEPTH_LOG
)
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush,
   // From fetch controller
   fetch_push_if.consumer push,
   // To decode
   output logic           id_valid,
   input  logic           id_ready,
   output fetch_entry_t   head
);
   localparam int DEPTH = 1 << DEPTH_LOG;

   fetch_entry_t         mem [DEPTH];
   logic [DEPTH_LOG-1:0] rd_ptr;
   logic [DEPTH_LOG-1:0] wr_ptr;
   logic [DEPTH_LOG:0]   count;
   logic                 do_push;
   logic                 do_pop;

   assign push.ready = (count != (DEPTH_LOG+1)'(DEPTH));
   assign id_valid   = (count != '0);
   assign head       = mem[rd_ptr];

   assign do_push = push.valid & push.ready;
   assign do_pop  = id_valid & id_ready;

   // Pointers and occupancy, flush empties the queue
   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (do_push && !flush)
         mem[wr_ptr] <= push.entry;
   end

endmodule

/* verilog/frontend.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module frontend
   import fetch_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               flush,
   input  logic [`ADDR_W-1:0] flush_tgt,
   // To decode
   output logic               id_valid,
   input  logic               id_ready,
   output logic [`ADDR_W-1:0] id_pc,
   output logic [`INSN_W-1:0] id_ins,
   output logic               id_pred_taken,
   // BTB training from execute
   input  logic               bpu_wb,
   input  logic               bpu_wb_taken,
   input  logic [`ADDR_W-1:0] bpu_wb_pc,
   input  logic [`ADDR_W-1:0] bpu_wb_tgt,
   // Wishbone instruction bus
   output logic               wb_cyc,
   output logic               wb_stb,
   output logic [`ADDR_W-1:0] wb_adr,
   input  logic               wb_ack,
   input  logic [`INSN_W-1:0] wb_rdata
);
   logic [`ADDR_W-1:0] lookup_pc;
   logic               pred_hit;
   logic [`ADDR_W-1:0] pred_tgt;
   fetch_entry_t       head;

   fetch_push_if fq_push ();

   fetch_ctrl fetch_ctrl_i
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .flush_tgt (flush_tgt),
      .lookup_pc (lookup_pc),
      .pred_hit  (pred_hit),
      .pred_tgt  (pred_tgt),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_adr    (wb_adr),
      .wb_ack    (wb_ack),
      .wb_rdata  (wb_rdata),
      .push      (fq_push.producer)
   );

   btb #(.IDX_W(`BTB_IDX_W)) btb_i
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_pc    (lookup_pc),
      .pred_hit     (pred_hit),
      .pred_tgt     (pred_tgt),
      .bpu_wb       (bpu_wb),
      .bpu_wb_taken (bpu_wb_taken),
      .bpu_wb_pc    (bpu_wb_pc),
      .bpu_wb_tgt   (bpu_wb_tgt)
   );

   fetch_queue #(.DEPTH_LOG(`FQ_DEPTH_LOG)) fetch_queue_i
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .push     (fq_push.consumer),
      .id_valid (id_valid),
      .id_ready (id_ready),
      .head     (head)
   );

   // Head entry out to the decode ports
   assign id_pc         = head.pc;
   assign id_ins        = head.ins;
   assign id_pred_taken = head.pred_taken;

endmodule

/* verification/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen
#(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 16
)
(
   output logic clk,
   output logic rst_n
);
   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset released on a falling edge, same as the other stimulus
   initial
   begin
      rst_n = 1'b0;
      repeat (RST_CYCLES)
         @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* verification/tb_frontend.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_frontend;
   // Reset plus all test lengths and a margin
   localparam int CYCLE_LIMIT = 16 + 20 + 200 + 60 + 300 + 122 + 100;
   localparam logic [31:0] BR_PC  = 32'h0000_2010;
   localparam logic [31:0] BR_TGT = 32'h0000_2080;

   logic               clk;
   logic               rst_n;
   logic               flush;
   logic [`ADDR_W-1:0] flush_tgt;
   logic               id_valid;
   logic               id_ready;
   logic [`ADDR_W-1:0] id_pc;
   logic [`INSN_W-1:0] id_ins;
   logic               id_pred_taken;
   logic               bpu_wb;
   logic               bpu_wb_taken;
   logic [`ADDR_W-1:0] bpu_wb_pc;
   logic [`ADDR_W-1:0] bpu_wb_tgt;
   logic               wb_cyc;
   logic               wb_stb;
   logic [`ADDR_W-1:0] wb_adr;
   logic               wb_ack;
   logic [`INSN_W-1:0] wb_rdata;

   // Reference model state
   logic [15:0] lfsr = 16'd90;
   logic [32:0] exp_q [$];
   logic        btb_vld [16] = '{default: 1'b0};
   logic [25:0] btb_tag [16];
   logic [31:0] btb_tgt [16];
   logic [1:0]  btb_cnt [16];
   logic [31:0] mdl_pc = `RESET_PC;
   logic        discard = 1'b0;
   logic        in_cycle = 1'b0;
   // First bus cycle is open by the first sample after release
   logic        exp_cyc = 1'b1;
   logic [1:0]  delay = 2'd0;
   logic [32:0] last_pop = '0;
   logic [31:0] first_pc = '0;
   logic        seen_taken = 1'b0;
   logic        seen_not_taken = 1'b0;
   logic        after_flush = 1'b0;
   logic [31:0] flush_pc = '0;
   // Stimulus control and one-shot directed events
   logic [1:0]  ready_mode = 2'd0;
   logic        rand_events = 1'b0;
   logic        pend_flush = 1'b0;
   logic [31:0] pend_tgt = '0;
   logic        pend_bpu = 1'b0;
   logic        pend_taken = 1'b0;
   string       test_name = "none";
   int          errors = 0;
   int          test_err0 = 0;
   int          tests = 0;
   int          failed_tests = 0;
   int          pops = 0;
   int          flush_pops = 0;
   int          cycles = 0;

   tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(16)) clkgen_i (.clk(clk), .rst_n(rst_n));

   frontend frontend_i (.*);

   // Taps at x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Memory word as a hash of the full address
   function automatic logic [31:0] mem_word(input logic [31:0] a);
      return (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]};
   endfunction

   function automatic logic btb_hit(input logic [31:0] pc);
      return btb_vld[pc[5:2]] && (btb_tag[pc[5:2]] == pc[31:6])
         && (btb_cnt[pc[5:2]] >= 2'd2);
   endfunction

   task automatic btb_train(input logic taken, input logic [31:0] pc, input logic [31:0] tgt);
      logic [3:0] i;
      logic       match;
      i = pc[5:2];
      match = btb_vld[i] && (btb_tag[i] == pc[31:6]);
      if (taken && !match)
      begin
         btb_vld[i] = 1'b1;
         btb_tag[i] = pc[31:6];
         btb_tgt[i] = tgt;
         btb_cnt[i] = 2'd2;
      end
      else if (taken)
      begin
         btb_tgt[i] = tgt;
         if (btb_cnt[i] != 2'd3)
            btb_cnt[i] = btb_cnt[i] + 2'd1;
      end
      else if (match && btb_cnt[i] != 2'd0)
         btb_cnt[i] = btb_cnt[i] - 2'd1;
   endtask

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act)
      else
      begin
         $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   // One cycle of checks and drive, then the model update for the coming edge
   task automatic step();
      logic [32:0] ent;
      logic        ack_now;
      @(negedge clk);
      check_val("id_valid", 64'(exp_q.size() != 0), 64'(id_valid));
      check_val("wb_cyc", 64'(exp_cyc), 64'(wb_cyc));
      check_val("wb_stb", 64'(exp_cyc), 64'(wb_stb));
      assert (!(wb_cyc && exp_q.size() == 4))
      else
      begin
         $display("%s: bus cycle active while the queue holds 4 entries", test_name);
         errors++;
      end
      // Wishbone slave with 0 to 3 wait cycles
      if (wb_cyc && !in_cycle)
      begin
         in_cycle = 1'b1;
         delay = 2'(rand_bits(2));
         check_val("wb_adr", 64'(mdl_pc), 64'(wb_adr));
      end
      ack_now = in_cycle && (delay == 2'd0);
      if (in_cycle && delay != 2'd0)
         delay = delay - 2'd1;
      if (ack_now)
         in_cycle = 1'b0;
      wb_ack = ack_now;
      wb_rdata = ack_now ? mem_word(wb_adr) : 32'h0;
      id_ready = (ready_mode == 2'd2) ? (rand_bits(2) != 0) : ready_mode[0];
      flush = pend_flush || (rand_events && rand_bits(4) == 0);
      flush_tgt = pend_flush ? pend_tgt : 32'h1000 | (rand_bits(6) << 2);
      bpu_wb = pend_bpu || (rand_events && rand_bits(2) == 0);
      bpu_wb_taken = pend_bpu ? pend_taken : (rand_bits(1) != 0);
      bpu_wb_pc = pend_bpu ? BR_PC : 32'h1000 | (rand_bits(6) << 2);
      bpu_wb_tgt = pend_bpu ? BR_TGT : 32'h1000 | (rand_bits(6) << 2);
      pend_flush = 1'b0;
      pend_bpu = 1'b0;
      // Bus cycle after the edge: held until ack, dropped after it,
      // otherwise opened when the queue has room and no flush is pending
      if (ack_now)
         exp_cyc = 1'b0;
      else if (in_cycle)
         exp_cyc = 1'b1;
      else
         exp_cyc = (exp_q.size() != 4) && !flush;
      if (id_valid && id_ready && exp_q.size() != 0)
      begin
         ent = exp_q.pop_front();
         check_val("id_pc", 64'(ent[31:0]), 64'(id_pc));
         check_val("id_ins", 64'(mem_word(ent[31:0])), 64'(id_ins));
         check_val("id_pred_taken", 64'(ent[32]), 64'(id_pred_taken));
         if (after_flush)
         begin
            check_val("pc after flush", 64'(flush_pc), 64'(id_pc));
            after_flush = 1'b0;
            flush_pops++;
         end
         if (last_pop == {1'b1, BR_PC} && id_pc == BR_TGT)
            seen_taken = 1'b1;
         if (last_pop == {1'b0, BR_PC} && id_pc == BR_PC + 32'd4)
            seen_not_taken = 1'b1;
         if (pops == 0)
            first_pc = id_pc;
         last_pop = {id_pred_taken, id_pc};
         pops++;
      end
      // Prediction uses the BTB as it stands before this edge
      if (ack_now && !discard && !flush)
      begin
         exp_q.push_back({btb_hit(mdl_pc), mdl_pc});
         mdl_pc = btb_hit(mdl_pc) ? btb_tgt[mdl_pc[5:2]] : mdl_pc + 32'd4;
      end
      if (ack_now)
         discard = 1'b0;
      if (flush)
      begin
         exp_q.delete();
         mdl_pc = flush_tgt;
         discard = wb_cyc && !ack_now;
         after_flush = 1'b1;
         flush_pc = flush_tgt;
      end
      if (bpu_wb)
         btb_train(bpu_wb_taken, bpu_wb_pc, bpu_wb_tgt);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
   endtask

   task automatic finish_test();
      tests++;
      if (errors != test_err0)
         failed_tests++;
      $display("test %-12s %s", test_name, (errors == test_err0) ? "passed" : "failed");
   endtask

   initial
   begin
      flush = 1'b0;
      flush_tgt = '0;
      id_ready = 1'b0;
      bpu_wb = 1'b0;
      bpu_wb_taken = 1'b0;
      bpu_wb_pc = '0;
      bpu_wb_tgt = '0;
      wb_ack = 1'b0;
      wb_rdata = '0;

      begin_test("reset");
      repeat (15)
      begin
         @(negedge clk);
         assert (!wb_cyc && !id_valid)
         else
         begin
            $display("%s: bus or decode output active during reset", test_name);
            errors++;
         end
      end
      wait (rst_n === 1'b1);
      ready_mode = 2'd1;
      repeat (20)
         step();
      check_val("first pc", 64'(`RESET_PC), 64'(first_pc));
      finish_test();

      begin_test("sequential");
      ready_mode = 2'd2;
      repeat (200)
         step();
      finish_test();

      begin_test("backpressure");
      ready_mode = 2'd0;
      repeat (30)
         step();
      check_val("queued entries", 64'd4, 64'(exp_q.size()));
      ready_mode = 2'd1;
      repeat (30)
         step();
      finish_test();

      begin_test("flush");
      ready_mode = 2'd2;
      rand_events = 1'b1;
      repeat (300)
         step();
      rand_events = 1'b0;
      assert (flush_pops > 0)
      else
      begin
         $display("%s: no entry was delivered after a flush", test_name);
         errors++;
      end
      finish_test();

      begin_test("branch");
      ready_mode = 2'd1;
      pend_flush = 1'b1;
      pend_tgt = 32'h0000_2000;
      pend_bpu = 1'b1;
      pend_taken = 1'b1;
      repeat (60)
         step();
      assert (seen_taken)
      else
      begin
         $display("%s: branch at %h was not predicted to %h", test_name, BR_PC, BR_TGT);
         errors++;
      end
      // Two not-taken updates drop the counter below the hit threshold
      pend_bpu = 1'b1;
      pend_taken = 1'b0;
      step();
      pend_bpu = 1'b1;
      pend_taken = 1'b0;
      step();
      pend_flush = 1'b1;
      pend_tgt = 32'h0000_2000;
      repeat (60)
         step();
      assert (seen_not_taken)
      else
      begin
         $display("%s: branch at %h still predicted after not-taken updates", test_name, BR_PC);
         errors++;
      end
      finish_test();

      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("FAIL: see errors above");
         $finish;
      end
   end

endmodule

/* sim.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_push_if.sv
verilog/btb.sv
verilog/fetch_ctrl.sv
verilog/fetch_queue.sv
verilog/frontend.sv
verification/tb_clkgen.sv
verification/tb_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_frontend -o tb_frontend
./obj_dir/tb_frontend | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
